// ==== design/rvPkg.sv ====
`default_nettype none

package rvPkg;

	localparam int XLen = 32;
	localparam int RegIdxW = 5;

	typedef logic [XLen-1:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [RegIdxW-1:0] regNum_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] func3_t;
	typedef logic [6:0] func7_t;

	// Major opcodes
	localparam opcode_t OpImm = 7'b0010011;
	localparam opcode_t Op = 7'b0110011;
	localparam opcode_t Lui = 7'b0110111;
	localparam opcode_t Auipc = 7'b0010111;
	localparam opcode_t Jal = 7'b1101111;
	localparam opcode_t Jalr = 7'b1100111;
	localparam opcode_t Branch = 7'b1100011;
	localparam opcode_t Store = 7'b0100011; // S format immediate only
	localparam opcode_t System = 7'b1110011;

	// ALU func3 codes
	localparam func3_t F3Add = 3'b000;
	localparam func3_t F3Sll = 3'b001;
	localparam func3_t F3Slt = 3'b010;
	localparam func3_t F3Sltu = 3'b011;
	localparam func3_t F3Xor = 3'b100;
	localparam func3_t F3Sr = 3'b101;
	localparam func3_t F3Or = 3'b110;
	localparam func3_t F3And = 3'b111;

	// Branch func3 codes
	localparam func3_t Beq = 3'b000;
	localparam func3_t Bne = 3'b001;
	localparam func3_t Blt = 3'b100;
	localparam func3_t Bge = 3'b101;
	localparam func3_t Bltu = 3'b110;
	localparam func3_t Bgeu = 3'b111;

	localparam func7_t Func7Alt = 7'b0100000; // SUB and SRA

	localparam word_t ResetPc = 32'h0000_0000;
	localparam instr_t NopInstr = 32'h0000_0013; // ADDI x0,x0,0

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluSll, AluSlt, AluSltu, AluXor,
		AluSrl, AluSra, AluOr, AluAnd, AluPassB
	} aluOp_e;

	typedef enum logic [1:0] {
		Idle, Run, Flush, Halt
	} ctrlState_e;

	typedef struct packed {
		logic valid;
		word_t pc;
		opcode_t opcode;
		func3_t func3;
		aluOp_e aluOp;
		logic useImm;
		word_t rs1Data;
		word_t rs2Data;
		word_t imm;
		regNum_t rd;
	} decodeBundle_t;

	typedef struct packed {
		logic valid;
		regNum_t rd;
		word_t data;
	} wbBundle_t;

	typedef struct packed {
		logic taken;
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire

// ==== design/immGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module immGen (
	input  rvPkg::instr_t instr,
	output rvPkg::word_t  imm
);

	import rvPkg::*;

	opcode_t opcode;
	func3_t func3;

	assign opcode = instr[6:0];
	assign func3 = instr[14:12];

	always_comb
	begin
		case (opcode)
			OpImm:
			begin
				if (func3 == F3Sll || func3 == F3Sr)
					imm = {20'b0, instr[31:20]}; // Zero-extended shift amount
				else
					imm = {{20{instr[31]}}, instr[31:20]};
			end
			Jalr, System:
				imm = {{20{instr[31]}}, instr[31:20]}; // I format
			Store:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			Branch:
				imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			Lui, Auipc:
				imm = {instr[31:12], 12'b0};
			Jal:
				imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input  logic              clk,
	input  logic              arstN,
	input  rvPkg::regNum_t    rs1,
	input  rvPkg::regNum_t    rs2,
	output rvPkg::word_t      rs1Data,
	output rvPkg::word_t      rs2Data,
	input  rvPkg::wbBundle_t  wb
);

	import rvPkg::*;

	word_t regs [2**RegIdxW];

	// Old value during a same-cycle write and forwarding covers it
	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 2**RegIdxW; i++)
				regs[i] <= '0;
		end
		else if (wb.valid && wb.rd != '0) // x0 stays zero
			regs[wb.rd] <= wb.data;
	end

endmodule

`default_nettype wire

// ==== design/forwardUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module forwardUnit (
	input  rvPkg::regNum_t    rs1,
	input  rvPkg::regNum_t    rs2,
	input  rvPkg::wbBundle_t  exFwd,
	input  rvPkg::wbBundle_t  wbFwd,
	input  rvPkg::word_t      rfData1,
	input  rvPkg::word_t      rfData2,
	output rvPkg::word_t      op1,
	output rvPkg::word_t      op2
);

	import rvPkg::*;

	// Execute beats writeback, writeback beats the register file
	function automatic word_t pickOperand(regNum_t rs, word_t rfData, wbBundle_t ex,
		wbBundle_t wbr);
		if (rs == '0)
			return rfData; // x0 never forwarded
		if (ex.valid && ex.rd == rs)
			return ex.data;
		if (wbr.valid && wbr.rd == rs)
			return wbr.data;
		return rfData;
	endfunction

	assign op1 = pickOperand(rs1, rfData1, exFwd, wbFwd);
	assign op2 = pickOperand(rs2, rfData2, exFwd, wbFwd);

endmodule

`default_nettype wire

// ==== design/aluExec.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluExec (
	input  logic                  clk,
	input  logic                  arstN,
	input  rvPkg::decodeBundle_t  bundle,
	output rvPkg::wbBundle_t      exFwd,
	output rvPkg::wbBundle_t      wb,
	output rvPkg::redirect_t      redirect,
	output logic                  haltReq
);

	import rvPkg::*;

	word_t opA;
	word_t opB;
	word_t aluResult;
	word_t result;
	word_t jalrSum;
	logic [4:0] shamt;
	logic branchTaken;
	logic writesRd;

	assign opA = (bundle.opcode == Auipc) ? bundle.pc : bundle.rs1Data;
	assign opB = bundle.useImm ? bundle.imm : bundle.rs2Data;
	assign shamt = opB[4:0];

	always_comb
	begin
		case (bundle.aluOp)
			AluAdd: aluResult = opA + opB;
			AluSub: aluResult = opA - opB;
			AluSll: aluResult = opA << shamt;
			AluSlt: aluResult = word_t'($signed(opA) < $signed(opB));
			AluSltu: aluResult = word_t'(opA < opB);
			AluXor: aluResult = opA ^ opB;
			AluSrl: aluResult = opA >> shamt;
			AluSra: aluResult = word_t'($signed(opA) >>> shamt);
			AluOr: aluResult = opA | opB;
			AluAnd: aluResult = opA & opB;
			AluPassB: aluResult = opB; // LUI
			default: aluResult = '0;
		endcase
	end

	// Jumps write the link address
	assign result = (bundle.opcode == Jal || bundle.opcode == Jalr) ?
		bundle.pc + 32'd4 : aluResult;

	always_comb
	begin
		case (bundle.func3)
			Beq: branchTaken = (bundle.rs1Data == bundle.rs2Data);
			Bne: branchTaken = (bundle.rs1Data != bundle.rs2Data);
			Blt: branchTaken = ($signed(bundle.rs1Data) < $signed(bundle.rs2Data));
			Bge: branchTaken = ($signed(bundle.rs1Data) >= $signed(bundle.rs2Data));
			Bltu: branchTaken = (bundle.rs1Data < bundle.rs2Data);
			Bgeu: branchTaken = (bundle.rs1Data >= bundle.rs2Data);
			default: branchTaken = 1'b0;
		endcase
	end

	assign jalrSum = bundle.rs1Data + bundle.imm;
	assign writesRd = bundle.opcode inside {OpImm, Op, Lui, Auipc, Jal, Jalr};

	always_comb
	begin
		redirect.taken = bundle.valid && (bundle.opcode == Jal || bundle.opcode == Jalr ||
			(bundle.opcode == Branch && branchTaken));
		if (bundle.opcode == Jalr)
			redirect.target = {jalrSum[XLen-1:1], 1'b0}; // Low bit cleared
		else
			redirect.target = bundle.pc + bundle.imm;
	end

	assign haltReq = bundle.valid && (bundle.opcode == System);

	always_comb
	begin
		exFwd.valid = bundle.valid && writesRd;
		exFwd.rd = bundle.rd;
		exFwd.data = result;
	end

	// Writeback register
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			wb <= '0;
		else
			wb <= exFwd;
	end

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
	input  logic              clk,
	input  logic              arstN,
	input  rvPkg::instr_t     instr,
	input  rvPkg::word_t      pc,
	input  logic              fetchEnable,
	input  logic              flush,
	output rvPkg::redirect_t  redirect,
	output logic              haltReq,
	output rvPkg::wbBundle_t  wb
);

	import rvPkg::*;

	logic slotValid;
	instr_t decInstr;
	opcode_t opcode;
	func3_t func3;
	func7_t func7;
	regNum_t rd;
	regNum_t rs1;
	regNum_t rs2;
	word_t rfData1;
	word_t rfData2;
	word_t op1;
	word_t op2;
	word_t imm;
	aluOp_e aluOp;
	logic useImm;
	decodeBundle_t exBundle;
	wbBundle_t exFwd;

	// Dead slots decode as a NOP
	assign slotValid = fetchEnable && !flush;
	assign decInstr = slotValid ? instr : NopInstr;

	assign opcode = decInstr[6:0];
	assign rd = decInstr[11:7];
	assign func3 = decInstr[14:12];
	assign rs1 = decInstr[19:15];
	assign rs2 = decInstr[24:20];
	assign func7 = decInstr[31:25];

	always_comb
	begin
		aluOp = AluAdd;
		useImm = 1'b1;
		case (opcode)
			Op, OpImm:
			begin
				useImm = (opcode == OpImm);
				case (func3)
					F3Add: aluOp = (opcode == Op && func7 == Func7Alt) ? AluSub : AluAdd;
					F3Sll: aluOp = AluSll;
					F3Slt: aluOp = AluSlt;
					F3Sltu: aluOp = AluSltu;
					F3Xor: aluOp = AluXor;
					F3Sr: aluOp = (func7 == Func7Alt) ? AluSra : AluSrl; // SRAI too
					F3Or: aluOp = AluOr;
					F3And: aluOp = AluAnd;
				endcase
			end
			Lui: aluOp = AluPassB;
			Branch: useImm = 1'b0; // Compare on rs2
			default: ;
		endcase
	end

	regFile uRegFile (
		.clk     (clk),
		.arstN   (arstN),
		.rs1     (rs1),
		.rs2     (rs2),
		.rs1Data (rfData1),
		.rs2Data (rfData2),
		.wb      (wb)
	);

	immGen uImmGen (
		.instr (decInstr),
		.imm   (imm)
	);

	forwardUnit uForward (
		.rs1     (rs1),
		.rs2     (rs2),
		.exFwd   (exFwd),
		.wbFwd   (wb),
		.rfData1 (rfData1),
		.rfData2 (rfData2),
		.op1     (op1),
		.op2     (op2)
	);

	// Decode to execute register
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			exBundle <= '0;
		else
		begin
			exBundle.valid <= slotValid;
			exBundle.pc <= pc;
			exBundle.opcode <= opcode;
			exBundle.func3 <= func3;
			exBundle.aluOp <= aluOp;
			exBundle.useImm <= useImm;
			exBundle.rs1Data <= op1;
			exBundle.rs2Data <= op2;
			exBundle.imm <= imm;
			exBundle.rd <= rd;
		end
	end

	aluExec uExec (
		.clk      (clk),
		.arstN    (arstN),
		.bundle   (exBundle),
		.exFwd    (exFwd),
		.wb       (wb),
		.redirect (redirect),
		.haltReq  (haltReq)
	);

endmodule

`default_nettype wire

// ==== design/programCounter.sv ====
`timescale 1ns/10ps
`default_nettype none

module programCounter (
	input  logic              clk,
	input  logic              arstN,
	input  logic              fetchEnable,
	input  rvPkg::redirect_t  redirect,
	output rvPkg::word_t      fetchAddr
);

	import rvPkg::*;

	word_t pcNext;

	// Redirect wins over the sequential step
	always_comb
	begin
		if (redirect.taken)
			pcNext = redirect.target;
		else if (fetchEnable)
			pcNext = fetchAddr + 32'd4;
		else
			pcNext = fetchAddr; // Hold while stopped
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			fetchAddr <= ResetPc;
		else
			fetchAddr <= pcNext;
	end

endmodule

`default_nettype wire

// ==== design/coreControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreControl (
	input  logic              clk,
	input  logic              arstN,
	input  logic              start,
	input  rvPkg::redirect_t  redirect,
	input  logic              haltReq,
	output logic              fetchEnable,
	output logic              flush,
	output logic              halted
);

	import rvPkg::*;

	ctrlState_e state;
	ctrlState_e stateNext;

	always_comb
	begin
		stateNext = state;
		case (state)
			Idle: if (start) stateNext = Run;
			Run, Flush:
			begin
				if (haltReq)
					stateNext = Halt;
				else if (redirect.taken)
					stateNext = Flush;
				else
					stateNext = Run;
			end
			Halt: stateNext = Halt; // Only reset leaves
			default: stateNext = Idle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			state <= Idle;
		else
			state <= stateNext;
	end

	assign fetchEnable = (state == Run) || (state == Flush);
	assign halted = (state == Halt);

	// Kill the slot behind a jump or a halt in execute
	assign flush = fetchEnable && (redirect.taken || haltReq);

endmodule

`default_nettype wire

// ==== design/rvCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvCore (
	input  logic              clk,
	input  logic              arstN,
	input  logic              start,
	input  rvPkg::instr_t     instr,
	output rvPkg::word_t      fetchAddr,
	output rvPkg::wbBundle_t  wb,
	output logic              halted
);

	import rvPkg::*;

	logic fetchEnable;
	logic flush;
	logic haltReq;
	redirect_t redirect;

	coreControl uControl (
		.clk         (clk),
		.arstN       (arstN),
		.start       (start),
		.redirect    (redirect),
		.haltReq     (haltReq),
		.fetchEnable (fetchEnable),
		.flush       (flush),
		.halted      (halted)
	);

	programCounter uPc (
		.clk         (clk),
		.arstN       (arstN),
		.fetchEnable (fetchEnable),
		.redirect    (redirect),
		.fetchAddr   (fetchAddr)
	);

	decodeStage uDecode (
		.clk         (clk),
		.arstN       (arstN),
		.instr       (instr),
		.pc          (fetchAddr), // Same-cycle instruction memory
		.fetchEnable (fetchEnable),
		.flush       (flush),
		.redirect    (redirect),
		.haltReq     (haltReq),
		.wb          (wb)
	);

endmodule

`default_nettype wire

// ==== dv/coreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreTb;

	import rvPkg::*;

	localparam int ResetCycles = 5;
	localparam int MaxWords = 1024;
	localparam int MaxProg = 256;
	localparam int IdleChecks = 3;
	localparam int DrainCycles = 4;

	logic clk;
	logic arstN;
	logic start;
	instr_t instr;
	word_t fetchAddr;
	wbBundle_t wb;
	logic halted;

	logic [31:0] fileWords [0:MaxWords-1];
	instr_t progMem [0:MaxProg-1];
	logic [31:0] expRd [0:MaxProg-1];
	word_t expData [0:MaxProg-1];
	word_t haltAddr;
	word_t lastFetch;
	int progLen;
	int recCount;
	int recIdx;
	int cycleCount;
	int timeoutLimit;

	rvCore dut (
		.clk       (clk),
		.arstN     (arstN),
		.start     (start),
		.instr     (instr),
		.fetchAddr (fetchAddr),
		.wb        (wb),
		.halted    (halted)
	);

	// Same-cycle ROM that returns a NOP outside the program
	assign instr = (fetchAddr[1:0] == 2'b00 && fetchAddr[31:2] < progLen) ?
		progMem[fetchAddr[9:2]] : NopInstr;

	always #5 clk = ~clk;

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkEqual(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Error at %0t: %s expected %h, got %h",
				$time, name, expected, actual));
	endtask

	// Header, program, rd/data pairs, last fetch address
	task automatic loadPatterns();
		int base;
		$readmemh("dv/corePatterns.hex", fileWords);
		if ($isunknown(fileWords[0]) || $isunknown(fileWords[1]))
			stopWithFailure("Pattern file dv/corePatterns.hex is missing or has no header");
		progLen = fileWords[0];
		recCount = fileWords[1];
		if (progLen < 1 || progLen > MaxProg || recCount < 1 || recCount > MaxProg)
			stopWithFailure("Pattern file header gives a size out of range");
		for (int i = 0; i < progLen; i++)
			progMem[i] = fileWords[2 + i];
		base = 2 + progLen;
		for (int i = 0; i < recCount; i++)
		begin
			expRd[i] = fileWords[base + 2 * i];
			expData[i] = fileWords[base + 2 * i + 1];
		end
		haltAddr = fileWords[base + 2 * recCount];
		if ($isunknown(haltAddr))
			stopWithFailure("Pattern file ends before the halt address");
	endtask

	task automatic checkRecord();
		if (recIdx >= recCount)
			stopWithFailure($sformatf("Unexpected writeback to x%0d beyond the %0d expected",
				wb.rd, recCount));
		checkEqual($sformatf("wb.rd (record %0d)", recIdx), expRd[recIdx], 32'(wb.rd));
		checkEqual($sformatf("wb.data (record %0d)", recIdx), expData[recIdx], wb.data);
		recIdx++;
	endtask

	// Run limit
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit)
			stopWithFailure($sformatf("Timeout: core did not halt within %0d cycles",
				timeoutLimit));
	end

	initial
	begin
		clk = 1'b0;
		arstN = 1'b0;
		start = 1'b0;
		recIdx = 0;
		cycleCount = 0;
		timeoutLimit = 0;
		lastFetch = '0;
		loadPatterns();
		timeoutLimit = 4 * (progLen + recCount) + ResetCycles;

		repeat (ResetCycles) @(posedge clk);
		arstN <= 1'b1;

		// Core must sit still until start
		repeat (IdleChecks)
		begin
			@(negedge clk);
			checkEqual("wb.valid", 32'd0, 32'(wb.valid));
			checkEqual("halted", 32'd0, 32'(halted));
			checkEqual("fetchAddr", 32'd0, fetchAddr);
		end

		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;

		while (!halted)
		begin
			@(negedge clk);
			if (wb.valid)
				checkRecord();
			if (!halted)
				lastFetch = fetchAddr; // Frozen once halted
		end
		checkEqual("fetchAddr before halt", haltAddr, lastFetch);

		// Nothing retires after halt
		repeat (DrainCycles)
		begin
			@(negedge clk);
			if (wb.valid)
				stopWithFailure("A writeback record appeared after the core halted");
			checkEqual("halted", 32'd1, 32'(halted));
		end
		checkEqual("record count", recCount, recIdx);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/corePatterns.hex ====
// Header: program word count, writeback record count. Then program words from address 0,
// then expected writeback records as rd data pairs, then the last fetch address before halt
00000027 00000019
00500093 FFD08113 002081B3 40308233 // 00 addi x1, addi x2, add x3, sub x4
002192B3 00122333 001233B3 00524433 // 10 sll, slt, sltu, xor
002254B3 40225533 0022E5B3 00327633 // 20 srl, sra, or, and
00409693 01C25713 40445793 12345837 // 30 slli, srli, srai, lui
00001897 FFF84913 FFF22993 00900013 // 40 auipc, xori, slti, addi x0
00100A33 01408463 06300A93 01409463 // 50 add x20 from x0, beq taken, shadow, bne not taken
00100A93 00124463 06300A93 00127463 // 60 addi x21, blt taken, shadow, bgeu taken
06300A93 00126463 0040D463 06300A93 // 70 shadow, bltu not taken, bge taken, shadow
00800B6F 06300A93 00DB0BE7 06300A93 // 80 jal x22, shadow, jalr x23, shadow
017B0C33 00100073 00100C93          // 90 add x24, ebreak, dropped
01 00000005 02 00000002 03 00000007
04 FFFFFFFE 05 0000001C 06 00000001
07 00000000 08 FFFFFFE2 09 3FFFFFFF
0A FFFFFFFF 0B 0000001E 0C 00000006
0D 00000050 0E 0000000F 0F FFFFFFFE
10 12345000 11 00001040 12 EDCBAFFF
13 00000001 00 00000009 14 00000005
15 00000001 16 00000084 17 0000008C
18 00000110
00000098

// ==== verilog.f ====
design/rvPkg.sv
design/immGen.sv
design/regFile.sv
design/forwardUnit.sv
design/aluExec.sv
design/decodeStage.sv
design/programCounter.sv
design/coreControl.sv
design/rvCore.sv
dv/coreTb.sv
